//--- Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
LINT_TOP  ?= cache
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_tb;

	import cache_pkg::*;

	localparam int NUM_RANDOM   = 2000;
	localparam int ACCESS_LIMIT = 40;   // Loop passes before a request counts as hung
	localparam int REGION_WORDS = 256;  // 1 KB region
	localparam int REGION_LINES = REGION_WORDS / `CACHE_WORDS_PER_LINE;
	localparam int WORD_SEL     = $clog2(REGION_WORDS);
	localparam int LINE_SEL     = $clog2(REGION_LINES);

	logic     clk;
	logic     rst;
	addr_t    mem_address;
	logic     mem_read;
	logic     mem_write;
	word_t    mem_wdata;
	byte_en_t mem_byte_enable;
	word_t    mem_rdata;
	logic     mem_resp;
	addr_t    pmem_address;
	line_t    pmem_wdata;
	logic     pmem_read;
	logic     pmem_write;
	line_t    pmem_rdata;
	logic     pmem_resp;

	integer seed;

	word_t flat_mem [REGION_WORDS];   // Memory as the processor sees it
	line_t phys_mem [REGION_LINES];   // Backing store behind the cache

	tag_t model_tag   [2][`CACHE_SETS];
	logic model_valid [2][`CACHE_SETS];
	logic model_dirty [2][`CACHE_SETS];
	logic model_lru   [`CACHE_SETS];   // Next victim way

	cache uut (
		.clk             (clk),
		.rst             (rst),
		.mem_address     (mem_address),
		.mem_read        (mem_read),
		.mem_write       (mem_write),
		.mem_wdata       (mem_wdata),
		.mem_byte_enable (mem_byte_enable),
		.mem_rdata       (mem_rdata),
		.mem_resp        (mem_resp),
		.pmem_address    (pmem_address),
		.pmem_wdata      (pmem_wdata),
		.pmem_read       (pmem_read),
		.pmem_write      (pmem_write),
		.pmem_rdata      (pmem_rdata),
		.pmem_resp       (pmem_resp)
	);

	always #5 clk = ~clk;

	function automatic word_t init_word(addr_t a);
		return (a * 32'h9e37_79b1) ^ {a[7:0], a[31:8]} ^ 32'h3c5a_96e1;
	endfunction

	function automatic index_t addr_index(addr_t a);
		return a[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
	endfunction

	function automatic tag_t addr_tag(addr_t a);
		return a[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_BITS];
	endfunction

	function automatic line_t flat_line(addr_t a);
		line_t l;
		int    base;
		base = int'(a[`CACHE_OFFSET_BITS +: LINE_SEL]) * `CACHE_WORDS_PER_LINE;
		for (int i = 0; i < `CACHE_WORDS_PER_LINE; i++) begin
			l[i*`CACHE_WORD_BITS +: `CACHE_WORD_BITS] = flat_mem[base + i];
		end
		return l;
	endfunction

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			stop_run($sformatf("ERR %0t: %s got %h expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_line(input line_t got, input line_t exp, input string what);
		if (got !== exp) begin
			stop_run($sformatf("ERR %0t: %s got %h expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input string what);
		if (got !== exp) begin
			stop_run($sformatf("ERR %0t: %s got %h expected %h", $time, what, got, exp));
		end
	endtask

	// Called at the negedge where a command is first seen
	task automatic serve_pmem(input logic is_write, input addr_t line_addr, input line_t wdata);
		word_t rnd;
		int    delay;
		int    slot;
		rnd   = $random(seed);
		delay = 1 + int'(rnd[1:0]);
		slot  = int'(line_addr[`CACHE_OFFSET_BITS +: LINE_SEL]);
		if (is_write) begin
			phys_mem[slot] = wdata;
		end
		for (int i = 1; i < delay; i++) begin
			@(negedge clk);
			if (is_write ? !pmem_write : !pmem_read) begin
				stop_run("The cache dropped its memory command before the response came");
			end
		end
		@(posedge clk);
		#1;
		pmem_resp = 1'b1;
		if (!is_write) begin
			pmem_rdata = phys_mem[slot];
		end
		@(posedge clk);
		#1;
		pmem_resp  = 1'b0;
		pmem_rdata = '0;
	endtask

	// Starts and ends just after a rising edge
	task automatic run_access(input addr_t a, input logic wr, input word_t wdata,
	                          input byte_en_t be, output logic missed);
		index_t set;
		tag_t   tag;
		addr_t  victim_addr;
		logic   hit_pred;
		logic   wb_pred;
		logic   seen_wb;
		logic   seen_fill;
		logic   done;
		int     hit_way;
		int     victim;
		int     cycles;
		int     widx;

		set       = addr_index(a);
		tag       = addr_tag(a);
		widx      = int'(a[`CACHE_BYTE_SEL_BITS +: WORD_SEL]);
		hit_pred  = 1'b0;
		hit_way   = 0;
		for (int w = 0; w < 2; w++) begin
			if (model_valid[w][set] && model_tag[w][set] == tag) begin
				hit_pred = 1'b1;
				hit_way  = w;
			end
		end
		victim      = int'(model_lru[set]);
		wb_pred     = !hit_pred && model_valid[victim][set] && model_dirty[victim][set];
		victim_addr = {model_tag[victim][set], set, offset_t'(0)};

		mem_address     = a;
		mem_read        = !wr;
		mem_write       = wr;
		mem_wdata       = wdata;
		mem_byte_enable = be;

		seen_wb   = 1'b0;
		seen_fill = 1'b0;
		done      = 1'b0;
		cycles    = 0;
		while (!done) begin
			@(negedge clk);
			if (mem_resp) begin
				if (!hit_pred && !seen_fill) begin
					stop_run("A predicted miss completed without a line fill");
				end
				if (!wr) begin
					check_word(mem_rdata, flat_mem[widx], "read data");
				end
				done = 1'b1;
			end else if (pmem_write) begin
				if (!wb_pred || seen_wb) begin
					stop_run("The cache wrote back a line that the model holds clean or absent");
				end
				check_addr(pmem_address, victim_addr, "writeback address");
				check_line(pmem_wdata, flat_line(victim_addr), "writeback data");
				serve_pmem(1'b1, victim_addr, pmem_wdata);
				seen_wb = 1'b1;
			end else if (pmem_read) begin
				if (hit_pred) begin
					stop_run("The cache read memory on an access the model predicts as a hit");
				end
				if (wb_pred && !seen_wb) begin
					stop_run("The cache filled a line before writing back its dirty victim");
				end
				check_addr(pmem_address, {tag, set, offset_t'(0)}, "fill address");
				serve_pmem(1'b0, pmem_address, '0);
				seen_fill = 1'b1;
			end
			cycles++;
			if (!done && cycles > ACCESS_LIMIT) begin
				stop_run("A request hung with no response from the cache");
			end
		end
		@(posedge clk);
		#1;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		missed    = seen_fill;

		if (!hit_pred) begin
			hit_way                   = victim;
			model_tag[victim][set]    = tag;
			model_valid[victim][set]  = 1'b1;
			model_dirty[victim][set]  = 1'b0;
		end
		model_lru[set] = (hit_way == 0);
		if (wr) begin
			model_dirty[hit_way][set] = 1'b1;
			for (int b = 0; b < `CACHE_WORD_BYTES; b++) begin
				if (be[b]) begin
					flat_mem[widx][b*8 +: 8] = wdata[b*8 +: 8];
				end
			end
		end
	endtask

	task automatic expect_miss(input addr_t a, input logic wr, input logic exp_miss,
	                           input string what);
		logic  missed;
		word_t wdata;
		wdata = $random(seed);
		run_access(a, wr, wdata, 4'hf, missed);
		if (missed !== exp_miss) begin
			stop_run($sformatf("%s: expected miss=%0b but the cache showed miss=%0b",
			                   what, exp_miss, missed));
		end
	endtask

	initial begin : main
		word_t rnd;
		word_t wdata;
		addr_t a;
		logic  missed;

		clk             = 1'b0;
		rst             = 1'b1;
		mem_address     = '0;
		mem_read        = 1'b0;
		mem_write       = 1'b0;
		mem_wdata       = '0;
		mem_byte_enable = '0;
		pmem_rdata      = '0;
		pmem_resp       = 1'b0;
		seed            = 32'hb6954ef1;

		for (int w = 0; w < REGION_WORDS; w++) begin
			flat_mem[w] = init_word(addr_t'(w * `CACHE_WORD_BYTES));
		end
		for (int l = 0; l < REGION_LINES; l++) begin
			phys_mem[l] = flat_line(addr_t'(l * `CACHE_LINE_BYTES));
		end
		for (int s = 0; s < `CACHE_SETS; s++) begin
			model_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++) begin
				model_tag[w][s]   = '0;
				model_valid[w][s] = 1'b0;
				model_dirty[w][s] = 1'b0;
			end
		end

		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		if (mem_resp !== 1'b0 || pmem_read !== 1'b0 || pmem_write !== 1'b0) begin
			stop_run("Cache outputs were not idle right after reset");
		end
		@(posedge clk);
		#1;

		// Lines A, B, C share set 3
		expect_miss(addr_t'('h064), 1'b1, 1'b1, "first write to A");
		expect_miss(addr_t'('h164), 1'b1, 1'b1, "first write to B");
		expect_miss(addr_t'('h064), 1'b0, 1'b0, "read of A");
		expect_miss(addr_t'('h264), 1'b0, 1'b1, "read of C");
		expect_miss(addr_t'('h064), 1'b0, 1'b0, "A kept after C");
		expect_miss(addr_t'('h164), 1'b0, 1'b1, "B evicted by C");

		for (int n = 0; n < NUM_RANDOM; n++) begin
			rnd   = $random(seed);
			wdata = $random(seed);
			a     = addr_t'({rnd[9:2], 2'b00});
			run_access(a, rnd[16], wdata, rnd[23:20], missed);
		end

		$display("All tests passed");
		$finish;
	end

endmodule : cache_tb

`default_nettype wire

//--- rtl/cache.sv
`timescale 1ns/1ps
`default_nettype none

module cache (
	input  wire logic                 clk,
	input  wire logic                 rst,

	input  wire cache_pkg::addr_t     mem_address,
	input  wire logic                 mem_read,
	input  wire logic                 mem_write,
	input  wire cache_pkg::word_t     mem_wdata,
	input  wire cache_pkg::byte_en_t  mem_byte_enable,
	output cache_pkg::word_t          mem_rdata,
	output logic                      mem_resp,

	output cache_pkg::addr_t          pmem_address,
	output cache_pkg::line_t          pmem_wdata,
	output logic                      pmem_read,
	output logic                      pmem_write,
	input  wire cache_pkg::line_t     pmem_rdata,
	input  wire logic                 pmem_resp
);

	import cache_pkg::*;

	logic [1:0]      hit;
	logic            lru_way;
	logic            victim_dirty;
	logic [1:0]      tag_load;
	logic [1:0]      valid_load;
	logic [1:0]      dirty_load;
	logic [1:0]      dirty_in;
	mask_sel_t [1:0] mask_sel;
	logic            lru_load;
	logic            pmem_addr_sel;

	cache_control control (
		.clk           (clk),
		.rst           (rst),
		.mem_read      (mem_read),
		.mem_write     (mem_write),
		.pmem_resp     (pmem_resp),
		.hit           (hit),
		.lru_way       (lru_way),
		.victim_dirty  (victim_dirty),
		.mem_resp      (mem_resp),
		.pmem_read     (pmem_read),
		.pmem_write    (pmem_write),
		.tag_load      (tag_load),
		.valid_load    (valid_load),
		.dirty_load    (dirty_load),
		.dirty_in      (dirty_in),
		.mask_sel      (mask_sel),
		.lru_load      (lru_load),
		.pmem_addr_sel (pmem_addr_sel)
	);

	cache_datapath datapath (
		.clk             (clk),
		.rst             (rst),
		.mem_address     (mem_address),
		.mem_wdata       (mem_wdata),
		.mem_byte_enable (mem_byte_enable),
		.pmem_rdata      (pmem_rdata),
		.tag_load        (tag_load),
		.valid_load      (valid_load),
		.dirty_load      (dirty_load),
		.dirty_in        (dirty_in),
		.mask_sel        (mask_sel),
		.lru_load        (lru_load),
		.pmem_addr_sel   (pmem_addr_sel),
		.hit             (hit),
		.lru_way         (lru_way),
		.victim_dirty    (victim_dirty),
		.mem_rdata       (mem_rdata),
		.pmem_address    (pmem_address),
		.pmem_wdata      (pmem_wdata)
	);

endmodule : cache

`default_nettype wire

//--- rtl/cache_control.sv
`timescale 1ns/1ps
`default_nettype none

module cache_control (
	input  wire logic                         clk,
	input  wire logic                         rst,

	input  wire logic                         mem_read,
	input  wire logic                         mem_write,
	input  wire logic                         pmem_resp,

	input  wire logic [1:0]                   hit,
	input  wire logic                         lru_way,
	input  wire logic                         victim_dirty,

	output logic                              mem_resp,
	output logic                              pmem_read,
	output logic                              pmem_write,

	output logic [1:0]                        tag_load,
	output logic [1:0]                        valid_load,
	output logic [1:0]                        dirty_load,
	output logic [1:0]                        dirty_in,
	output cache_pkg::mask_sel_t [1:0]        mask_sel,
	output logic                              lru_load,
	output logic                              pmem_addr_sel
);

	import cache_pkg::*;

	typedef enum logic [1:0] {
		check,
		allocate,
		writeback
	} ctrl_state_t;

	ctrl_state_t state;
	ctrl_state_t next_state;

	logic req;

	assign req = mem_read | mem_write;

	always_comb begin : state_actions
		tag_load      = '0;
		valid_load    = '0;
		dirty_load    = '0;
		dirty_in      = '0;
		mask_sel[0]   = mask_none;
		mask_sel[1]   = mask_none;
		lru_load      = 1'b0;
		pmem_addr_sel = 1'b0;
		mem_resp      = 1'b0;
		pmem_read     = 1'b0;
		pmem_write    = 1'b0;

		case (state)
			check: begin
				if (req && (|hit)) begin
					mem_resp = 1'b1;
					lru_load = 1'b1;   // Hit way becomes MRU
					if (mem_write) begin
						dirty_load = hit;
						dirty_in   = hit;
						for (int w = 0; w < 2; w++) begin
							if (hit[w]) begin
								mask_sel[w] = mask_cpu;
							end
						end
					end
				end
			end

			writeback: begin
				pmem_write    = 1'b1;
				pmem_addr_sel = 1'b1;   // Victim line address
				if (pmem_resp) begin
					dirty_load[lru_way] = 1'b1;   // dirty_in stays low
				end
			end

			allocate: begin
				pmem_read = 1'b1;
				if (pmem_resp) begin
					tag_load[lru_way]   = 1'b1;
					valid_load[lru_way] = 1'b1;
					dirty_load[lru_way] = 1'b1;   // Fresh line is clean
					mask_sel[lru_way]   = mask_fill;
				end
			end

			default: ;
		endcase
	end

	always_comb begin : next_state_logic
		next_state = state;

		case (state)
			check: begin
				if (req && !(|hit)) begin
					if (victim_dirty) begin
						next_state = writeback;
					end else begin
						next_state = allocate;
					end
				end
			end

			writeback: begin
				if (pmem_resp) begin
					next_state = allocate;
				end
			end

			allocate: begin
				if (pmem_resp) begin
					next_state = check;   // Request hits on return
				end
			end

			default: next_state = check;
		endcase
	end

	always_ff @(posedge clk) begin : state_reg
		if (rst) begin
			state <= check;
		end else begin
			state <= next_state;
		end
	end

endmodule : cache_control

`default_nettype wire

//--- rtl/cache_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_datapath (
	input  wire logic                         clk,
	input  wire logic                         rst,

	input  wire cache_pkg::addr_t             mem_address,
	input  wire cache_pkg::word_t             mem_wdata,
	input  wire cache_pkg::byte_en_t          mem_byte_enable,
	input  wire cache_pkg::line_t             pmem_rdata,

	input  wire logic [1:0]                   tag_load,
	input  wire logic [1:0]                   valid_load,
	input  wire logic [1:0]                   dirty_load,
	input  wire logic [1:0]                   dirty_in,
	input  wire cache_pkg::mask_sel_t [1:0]   mask_sel,
	input  wire logic                         lru_load,
	input  wire logic                         pmem_addr_sel,

	output logic [1:0]                        hit,
	output logic                              lru_way,
	output logic                              victim_dirty,
	output cache_pkg::word_t                  mem_rdata,
	output cache_pkg::addr_t                  pmem_address,
	output cache_pkg::line_t                  pmem_wdata
);

	import cache_pkg::*;

	localparam int WORD_SEL_BITS = `CACHE_OFFSET_BITS - `CACHE_BYTE_SEL_BITS;

	function automatic line_t merge_line(line_t old_line, line_t new_line, line_mask_t mask);
		line_t result;
		result = old_line;
		for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
			if (mask[b]) begin
				result[b*8 +: 8] = new_line[b*8 +: 8];
			end
		end
		return result;
	endfunction

	tag_t    req_tag;
	index_t  idx;
	offset_t off;

	logic [WORD_SEL_BITS-1:0] word_sel;

	// Way arrays
	line_t data_q [2][`CACHE_SETS];
	tag_t  tag_q  [2][`CACHE_SETS];
	logic [`CACHE_SETS-1:0] valid_q [2];
	logic [`CACHE_SETS-1:0] dirty_q [2];
	logic [`CACHE_SETS-1:0] lru_q;   // Way to evict next

	line_t      hit_line;
	line_t      cpu_line;
	line_mask_t cpu_mask;

	line_mask_t way_mask   [2];
	line_t      way_src    [2];
	line_t      way_merged [2];

	assign {req_tag, idx, off} = mem_address;
	assign word_sel = off[`CACHE_OFFSET_BITS-1:`CACHE_BYTE_SEL_BITS];

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			hit[w] = valid_q[w][idx] && (tag_q[w][idx] == req_tag);
		end
	end

	assign lru_way      = lru_q[idx];
	assign victim_dirty = dirty_q[lru_way][idx];

	// Read word out of the hit way
	assign hit_line  = hit[1] ? data_q[1][idx] : data_q[0][idx];
	assign mem_rdata = hit_line[word_sel*`CACHE_WORD_BITS +: `CACHE_WORD_BITS];

	// CPU word replicated across the line, enabled only in its slot
	assign cpu_line = {`CACHE_WORDS_PER_LINE{mem_wdata}};
	assign cpu_mask = line_mask_t'(mem_byte_enable) << (word_sel * `CACHE_WORD_BYTES);

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			case (mask_sel[w])
				mask_fill: begin
					way_mask[w] = '1;
					way_src[w]  = pmem_rdata;
				end
				mask_cpu: begin
					way_mask[w] = cpu_mask;
					way_src[w]  = cpu_line;
				end
				default: begin
					way_mask[w] = '0;
					way_src[w]  = cpu_line;
				end
			endcase
			way_merged[w] = merge_line(data_q[w][idx], way_src[w], way_mask[w]);
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < 2; w++) begin
			if (|way_mask[w]) begin
				data_q[w][idx] <= way_merged[w];
			end
			if (tag_load[w]) begin
				tag_q[w][idx] <= req_tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < 2; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
			lru_q <= '0;
		end else begin
			for (int w = 0; w < 2; w++) begin
				if (valid_load[w]) begin
					valid_q[w][idx] <= 1'b1;
				end
				if (dirty_load[w]) begin
					dirty_q[w][idx] <= dirty_in[w];
				end
			end
			if (lru_load) begin
				lru_q[idx] <= hit[0];   // Point at the way that missed
			end
		end
	end

	// Line aligned pmem address
	always_comb begin
		if (pmem_addr_sel) begin
			pmem_address = {tag_q[lru_way][idx], idx, offset_t'(0)};
		end else begin
			pmem_address = {req_tag, idx, offset_t'(0)};
		end
	end

	assign pmem_wdata = data_q[lru_way][idx];

endmodule : cache_datapath

`default_nettype wire

//--- rtl/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Cache geometry
`define CACHE_SETS           8
`define CACHE_LINE_BYTES     32
`define CACHE_ADDR_WIDTH     32
`define CACHE_WORD_BYTES     4

// Widths derived from the geometry
`define CACHE_INDEX_BITS     $clog2(`CACHE_SETS)
`define CACHE_OFFSET_BITS    $clog2(`CACHE_LINE_BYTES)
`define CACHE_TAG_BITS       (`CACHE_ADDR_WIDTH - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS)
`define CACHE_WORD_BITS      (`CACHE_WORD_BYTES * 8)
`define CACHE_LINE_BITS      (`CACHE_LINE_BYTES * 8)
`define CACHE_WORDS_PER_LINE (`CACHE_LINE_BYTES / `CACHE_WORD_BYTES)

// Byte address bits below the word select
`define CACHE_BYTE_SEL_BITS  $clog2(`CACHE_WORD_BYTES)

`endif

//--- rtl/cache_pkg.sv
`default_nettype none

`include "cache_defines.svh"

package cache_pkg;

	typedef logic [`CACHE_ADDR_WIDTH-1:0]  addr_t;
	typedef logic [`CACHE_WORD_BITS-1:0]   word_t;
	typedef logic [`CACHE_WORD_BYTES-1:0]  byte_en_t;
	typedef logic [`CACHE_LINE_BITS-1:0]   line_t;
	typedef logic [`CACHE_LINE_BYTES-1:0]  line_mask_t;   // One bit per line byte

	typedef logic [`CACHE_TAG_BITS-1:0]    tag_t;
	typedef logic [`CACHE_INDEX_BITS-1:0]  index_t;
	typedef logic [`CACHE_OFFSET_BITS-1:0] offset_t;

	// What a way writes on the next edge
	typedef enum logic [1:0] {
		mask_none,
		mask_fill,   // Whole line from pmem
		mask_cpu     // CPU word under byte enables
	} mask_sel_t;

endpackage : cache_pkg

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_control.sv
rtl/cache_datapath.sv
rtl/cache.sv
bench/cache_tb.sv
